//--- Bender.yml
package:
  name: roi_camera

sources:
  - common/roi_pkg.sv
  - capture/ccd_capture.sv
  - roi/roi_finder.sv
  - roi/roi_regs.sv
  - hdl/pixel_packer.sv
  - hdl/roi_camera_top.sv
  - target: simulation
    files:
      - tb/roi_camera_props.sv
      - tb/tb_roi_camera.sv

//--- capture/ccd_capture.sv
`timescale 1ns/1ps

module ccd_capture #(
	parameter int IMG_WIDTH  = roi_pkg::DEF_IMG_WIDTH,
	parameter int IMG_HEIGHT = roi_pkg::DEF_IMG_HEIGHT
) (
	input  logic              CCD_PIXCLK,
	input  logic              DLY_RST_1,
	input  roi_pkg::pix_t     ccd_data,
	input  logic              ccd_fval,
	input  logic              ccd_lval,
	input  logic              start,
	input  roi_pkg::pix_t     threshold,
	output roi_pkg::pix_bus_t pix
);

	// ========================================================================
	// Input registers
	// ========================================================================
	roi_pkg::pix_t r_data;
	logic          r_fval;
	logic          r_lval;
	logic          r_fval_d;  // Previous frame valid for edge detect
	logic          r_lval_d;

	always_ff @(posedge CCD_PIXCLK) begin
		r_data <= ccd_data;  // Raw sensor sample
	end

	always_ff @(posedge CCD_PIXCLK or negedge DLY_RST_1) begin
		if (!DLY_RST_1) begin
			r_fval   <= 1'b0;
			r_lval   <= 1'b0;
			r_fval_d <= 1'b0;
			r_lval_d <= 1'b0;
		end else begin
			r_fval   <= ccd_fval;
			r_lval   <= ccd_lval;
			r_fval_d <= r_fval;
			r_lval_d <= r_lval;
		end
	end

	// ========================================================================
	// Capture flag and counters
	// ========================================================================
	logic            frame_rise;
	logic            frame_fall;
	logic            line_fall;
	logic            capture;
	logic            cap_now;    // Capture flag as seen by this pixel
	logic            in_bounds;
	roi_pkg::coord_t x_cnt;
	roi_pkg::coord_t y_cnt;

	assign frame_rise = r_fval & ~r_fval_d;
	assign frame_fall = ~r_fval & r_fval_d;
	assign line_fall  = ~r_lval & r_lval_d;
	assign cap_now    = frame_rise ? start : capture;  // Start only counts at frame begin
	assign in_bounds  = (x_cnt < roi_pkg::coord_t'(IMG_WIDTH)) &&
		(y_cnt < roi_pkg::coord_t'(IMG_HEIGHT));

	always_ff @(posedge CCD_PIXCLK or negedge DLY_RST_1) begin
		if (!DLY_RST_1) begin
			capture <= 1'b0;
			x_cnt   <= '0;
			y_cnt   <= '0;
		end else begin
			if (frame_rise)
				capture <= start;
			else if (frame_fall)
				capture <= 1'b0;  // Frame in progress always runs to its end

			if (cap_now && r_lval) begin
				x_cnt <= x_cnt + 1'b1;
			end else if (cap_now && line_fall) begin
				x_cnt <= '0;
				y_cnt <= y_cnt + 1'b1;
			end
			if (frame_fall) begin  // Counters sit at zero between frames
				x_cnt <= '0;
				y_cnt <= '0;
			end
		end
	end

	// Threshold stage puts the pixel out two cycles after sampling
	always_ff @(posedge CCD_PIXCLK or negedge DLY_RST_1) begin
		if (!DLY_RST_1) begin
			pix <= '0;
		end else begin
			pix.valid       <= cap_now && r_lval && in_bounds;
			pix.white       <= (r_data >= threshold);
			pix.frame_start <= cap_now && r_lval && (x_cnt == '0) && (y_cnt == '0);
			pix.x           <= x_cnt;
			pix.y           <= y_cnt;
		end
	end

endmodule

//--- common/roi_pkg.sv
package roi_pkg;

	// ========================================================================
	// Widths with a meaning
	// ========================================================================
	typedef logic [11:0] pix_t;       // Raw sensor sample
	typedef logic [15:0] coord_t;     // Column or row count
	typedef logic [15:0] word_t;      // Packed word or register value
	typedef logic [2:0]  reg_addr_t;  // Wishbone word address

	// One thresholded pixel on its way to the finder and packer
	typedef struct packed {
		logic   valid;
		logic   white;
		logic   frame_start;  // First pixel of a captured frame
		coord_t x;
		coord_t y;
	} pix_bus_t;

	// Wishbone classic, host side
	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		reg_addr_t adr;
		word_t     dat;
	} wb_req_t;

	typedef struct packed {
		logic  ack;
		word_t dat;
	} wb_rsp_t;

	// Window search steps, in order
	typedef enum logic [2:0] {
		FIND_PROJ,
		FIND_TOP,
		FIND_LEFT,
		FIND_RIGHT,
		FIND_BOTTOM,
		ROI_DONE
	} roi_state_t;

	// Register map
	localparam reg_addr_t ADR_CTRL   = 3'd0;  // Bit 0 start, bit 1 done, bits 4:2 state
	localparam reg_addr_t ADR_THRESH = 3'd1;
	localparam reg_addr_t ADR_TOP    = 3'd2;
	localparam reg_addr_t ADR_LEFT   = 3'd3;
	localparam reg_addr_t ADR_RIGHT  = 3'd4;
	localparam reg_addr_t ADR_BOTTOM = 3'd5;

	localparam int PACK_WIDTH = 16;  // Pixels per memory word

	// Full sensor geometry
	localparam int DEF_IMG_WIDTH  = 1280;
	localparam int DEF_IMG_HEIGHT = 960;
	localparam int DEF_IMG_LEFT   = 128;
	localparam int DEF_IMG_RIGHT  = 1152;
	localparam int DEF_IMG_TOP    = 96;
	localparam int DEF_IMG_BOTTOM = 864;
	localparam int DEF_RUN_LEN    = 128;  // Line buffer length
	localparam int DEF_PROJ_GAP   = 50;   // Rows skipped below projection top
	localparam int DEF_ROW_GAP    = 24;   // Rows skipped below ROI top

endpackage

//--- hdl/pixel_packer.sv
`timescale 1ns/1ps

module pixel_packer (
	input  logic              CCD_PIXCLK,
	input  logic              DLY_RST_1,
	input  roi_pkg::pix_bus_t pix,
	output roi_pkg::word_t    pix_word,
	output logic              pix_word_valid
);

	localparam int CNT_W = $clog2(roi_pkg::PACK_WIDTH);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(roi_pkg::PACK_WIDTH - 1);

	logic [CNT_W-1:0] cnt;      // Pixels already in the word
	logic [CNT_W-1:0] cnt_now;  // Slot of the current pixel

	assign cnt_now = pix.frame_start ? '0 : cnt;  // Drop any partial word from last frame

	// ========================================================================
	// Shift register, first pixel ends in bit 0
	// ========================================================================
	always_ff @(posedge CCD_PIXCLK) begin
		if (pix.valid)
			pix_word <= {pix.white, pix_word[roi_pkg::PACK_WIDTH-1:1]};
	end

	always_ff @(posedge CCD_PIXCLK or negedge DLY_RST_1) begin
		if (!DLY_RST_1) begin
			cnt            <= '0;
			pix_word_valid <= 1'b0;
		end else begin
			pix_word_valid <= pix.valid && (cnt_now == LAST);  // One cycle strobe
			if (pix.valid)
				cnt <= cnt_now + 1'b1;  // Wraps after a full word
		end
	end

endmodule

//--- hdl/roi_camera_top.sv
`timescale 1ns/1ps

module roi_camera_top #(
	parameter int IMG_WIDTH  = roi_pkg::DEF_IMG_WIDTH,
	parameter int IMG_HEIGHT = roi_pkg::DEF_IMG_HEIGHT,
	parameter int IMG_LEFT   = roi_pkg::DEF_IMG_LEFT,
	parameter int IMG_RIGHT  = roi_pkg::DEF_IMG_RIGHT,
	parameter int IMG_TOP    = roi_pkg::DEF_IMG_TOP,
	parameter int IMG_BOTTOM = roi_pkg::DEF_IMG_BOTTOM,
	parameter int RUN_LEN    = roi_pkg::DEF_RUN_LEN,
	parameter int PROJ_GAP   = roi_pkg::DEF_PROJ_GAP,
	parameter int ROW_GAP    = roi_pkg::DEF_ROW_GAP
) (
	input  logic             CCD_PIXCLK,
	input  logic             DLY_RST_1,
	input  roi_pkg::pix_t    ccd_data,
	input  logic             ccd_fval,
	input  logic             ccd_lval,
	input  roi_pkg::wb_req_t wb_req,
	output roi_pkg::wb_rsp_t wb_rsp,
	output roi_pkg::word_t   pix_word,
	output logic             pix_word_valid
);

	// ========================================================================
	// Internal wiring
	// ========================================================================
	roi_pkg::pix_bus_t   pix;        // Thresholded stream
	logic                start;
	roi_pkg::pix_t       threshold;
	roi_pkg::roi_state_t state;
	roi_pkg::coord_t     roi_top;
	roi_pkg::coord_t     roi_left;
	roi_pkg::coord_t     roi_right;
	roi_pkg::coord_t     roi_bottom;

	ccd_capture #(
		.IMG_WIDTH (IMG_WIDTH),
		.IMG_HEIGHT(IMG_HEIGHT)
	) u_capture (
		.CCD_PIXCLK(CCD_PIXCLK),
		.DLY_RST_1 (DLY_RST_1),
		.ccd_data  (ccd_data),
		.ccd_fval  (ccd_fval),
		.ccd_lval  (ccd_lval),
		.start     (start),
		.threshold (threshold),
		.pix       (pix)
	);

	roi_finder #(
		.IMG_LEFT  (IMG_LEFT),
		.IMG_RIGHT (IMG_RIGHT),
		.IMG_TOP   (IMG_TOP),
		.IMG_BOTTOM(IMG_BOTTOM),
		.RUN_LEN   (RUN_LEN),
		.PROJ_GAP  (PROJ_GAP),
		.ROW_GAP   (ROW_GAP)
	) u_finder (
		.CCD_PIXCLK(CCD_PIXCLK),
		.DLY_RST_1 (DLY_RST_1),
		.pix       (pix),
		.state     (state),
		.roi_top   (roi_top),
		.roi_left  (roi_left),
		.roi_right (roi_right),
		.roi_bottom(roi_bottom)
	);

	pixel_packer u_packer (
		.CCD_PIXCLK    (CCD_PIXCLK),
		.DLY_RST_1     (DLY_RST_1),
		.pix           (pix),
		.pix_word      (pix_word),
		.pix_word_valid(pix_word_valid)
	);

	roi_regs u_regs (
		.CCD_PIXCLK(CCD_PIXCLK),
		.DLY_RST_1 (DLY_RST_1),
		.wb_req    (wb_req),
		.state     (state),
		.roi_top   (roi_top),
		.roi_left  (roi_left),
		.roi_right (roi_right),
		.roi_bottom(roi_bottom),
		.wb_rsp    (wb_rsp),
		.start     (start),
		.threshold (threshold)
	);

endmodule

//--- roi/roi_finder.sv
`timescale 1ns/1ps

module roi_finder #(
	parameter int IMG_LEFT   = roi_pkg::DEF_IMG_LEFT,
	parameter int IMG_RIGHT  = roi_pkg::DEF_IMG_RIGHT,
	parameter int IMG_TOP    = roi_pkg::DEF_IMG_TOP,
	parameter int IMG_BOTTOM = roi_pkg::DEF_IMG_BOTTOM,
	parameter int RUN_LEN    = roi_pkg::DEF_RUN_LEN,
	parameter int PROJ_GAP   = roi_pkg::DEF_PROJ_GAP,
	parameter int ROW_GAP    = roi_pkg::DEF_ROW_GAP
) (
	input  logic                CCD_PIXCLK,
	input  logic                DLY_RST_1,
	input  roi_pkg::pix_bus_t   pix,
	output roi_pkg::roi_state_t state,
	output roi_pkg::coord_t     roi_top,
	output roi_pkg::coord_t     roi_left,
	output roi_pkg::coord_t     roi_right,
	output roi_pkg::coord_t     roi_bottom
);

	// ========================================================================
	// Window geometry and edge patterns
	// ========================================================================
	localparam roi_pkg::coord_t X_L   = roi_pkg::coord_t'(IMG_LEFT);
	localparam roi_pkg::coord_t X_R   = roi_pkg::coord_t'(IMG_RIGHT);
	localparam roi_pkg::coord_t Y_T   = roi_pkg::coord_t'(IMG_TOP);
	localparam roi_pkg::coord_t Y_B   = roi_pkg::coord_t'(IMG_BOTTOM);
	localparam roi_pkg::coord_t X_MID = roi_pkg::coord_t'((IMG_LEFT + IMG_RIGHT) / 2);
	localparam roi_pkg::coord_t GAP_P = roi_pkg::coord_t'(PROJ_GAP);
	localparam roi_pkg::coord_t GAP_R = roi_pkg::coord_t'(ROW_GAP);

	localparam logic [RUN_LEN-1:0] ALL_WHITE = '1;
	// Old 3/4 white then new 1/4 black with the newest bit at 0
	localparam logic [RUN_LEN-1:0] PAT_FALL  = ALL_WHITE << (RUN_LEN / 4);
	localparam logic [RUN_LEN-1:0] PAT_RISE  = ALL_WHITE >> (RUN_LEN / 4);  // Mirror

	logic [RUN_LEN-1:0] line_buf;
	roi_pkg::coord_t    proj_top;   // Top row of projected white area
	logic               seen_l;     // Left edge seen on this row
	logic               seen_r;
	logic               in_win;
	logic               at_left;
	logic               left_half;
	logic               right_half;
	logic               fall_hit;
	logic               rise_hit;

	assign in_win     = pix.valid && (pix.x >= X_L) && (pix.x <= X_R) &&
		(pix.y >= Y_T) && (pix.y <= Y_B);
	assign at_left    = (pix.x == X_L);
	assign left_half  = (pix.x < X_MID);
	assign right_half = (pix.x > X_MID);
	assign fall_hit   = !at_left && left_half && (line_buf == PAT_FALL);
	assign rise_hit   = !at_left && right_half && (line_buf == PAT_RISE);

	// Line buffer cleared at window start of each row
	always_ff @(posedge CCD_PIXCLK) begin
		if (in_win) begin
			if (at_left)
				line_buf <= (state == roi_pkg::FIND_RIGHT) ? ALL_WHITE : '0;
			else
				line_buf <= {line_buf[RUN_LEN-2:0], pix.white};
		end
	end

	// ========================================================================
	// Search FSM
	// ========================================================================
	always_ff @(posedge CCD_PIXCLK or negedge DLY_RST_1) begin
		if (!DLY_RST_1) begin
			state      <= roi_pkg::FIND_PROJ;
			proj_top   <= '0;
			roi_top    <= '0;
			roi_left   <= '0;
			roi_right  <= '0;
			roi_bottom <= '0;
			seen_l     <= 1'b0;
			seen_r     <= 1'b0;
		end else begin
			if (pix.valid && pix.frame_start)
				state <= roi_pkg::FIND_PROJ;  // New frame starts a new search
			if (in_win) begin
				case (state)
					roi_pkg::FIND_PROJ: begin
						if (!at_left && left_half && line_buf == ALL_WHITE) begin
							proj_top <= pix.y;
							state    <= roi_pkg::FIND_TOP;
						end
					end
					roi_pkg::FIND_TOP: begin
						if (pix.y > proj_top + GAP_P && fall_hit) begin
							roi_top <= pix.y;
							state   <= roi_pkg::FIND_LEFT;
						end
					end
					roi_pkg::FIND_LEFT: begin
						if (pix.y > roi_top + GAP_R && fall_hit) begin
							roi_left <= pix.x;
							state    <= roi_pkg::FIND_RIGHT;
						end
					end
					roi_pkg::FIND_RIGHT: begin
						if (rise_hit)
							roi_right <= pix.x;  // Last match on the row wins
						if (pix.x == X_R)
							state <= roi_pkg::FIND_BOTTOM;
					end
					roi_pkg::FIND_BOTTOM: begin
						if (at_left) begin
							seen_l <= 1'b0;
							seen_r <= 1'b0;
						end else begin
							if (fall_hit)
								seen_l <= 1'b1;
							if (rise_hit)
								seen_r <= 1'b1;
						end
						// Row without either edge is below the ROI
						if (pix.x == X_R && !seen_l && !seen_r) begin
							roi_bottom <= pix.y;
							state      <= roi_pkg::ROI_DONE;
						end
					end
					roi_pkg::ROI_DONE: ;  // Hold until next frame so done stays readable
					default: state <= roi_pkg::FIND_PROJ;
				endcase
				// Unfinished search gives up at window bottom
				if (pix.y == Y_B && state != roi_pkg::ROI_DONE)
					state <= roi_pkg::FIND_PROJ;
			end
		end
	end

endmodule

//--- roi/roi_regs.sv
`timescale 1ns/1ps

module roi_regs (
	input  logic                CCD_PIXCLK,
	input  logic                DLY_RST_1,
	input  roi_pkg::wb_req_t    wb_req,
	input  roi_pkg::roi_state_t state,
	input  roi_pkg::coord_t     roi_top,
	input  roi_pkg::coord_t     roi_left,
	input  roi_pkg::coord_t     roi_right,
	input  roi_pkg::coord_t     roi_bottom,
	output roi_pkg::wb_rsp_t    wb_rsp,
	output logic                start,
	output roi_pkg::pix_t       threshold
);

	localparam roi_pkg::pix_t HALF_SCALE = {1'b1, {($bits(roi_pkg::pix_t) - 1){1'b0}}};

	logic           req;      // Classic cycle active
	logic           take;     // Request seen this cycle, ack follows
	logic           done;
	logic           ack;
	roi_pkg::word_t rd_mux;
	roi_pkg::word_t rd_dat;

	assign req  = wb_req.cyc & wb_req.stb;
	assign take = req & ~ack;  // No back to back ack
	assign done = (state == roi_pkg::ROI_DONE);

	// ========================================================================
	// Read mux
	// ========================================================================
	always_comb begin
		case (wb_req.adr)
			roi_pkg::ADR_CTRL:   rd_mux = {11'b0, state, done, start};
			roi_pkg::ADR_THRESH: rd_mux = roi_pkg::word_t'(threshold);  // Zero extended
			roi_pkg::ADR_TOP:    rd_mux = roi_top;
			roi_pkg::ADR_LEFT:   rd_mux = roi_left;
			roi_pkg::ADR_RIGHT:  rd_mux = roi_right;
			roi_pkg::ADR_BOTTOM: rd_mux = roi_bottom;
			default:             rd_mux = '0;  // Unmapped reads zero
		endcase
	end

	// Control, threshold and ack
	always_ff @(posedge CCD_PIXCLK or negedge DLY_RST_1) begin
		if (!DLY_RST_1) begin
			ack       <= 1'b0;
			start     <= 1'b0;
			threshold <= HALF_SCALE;
		end else begin
			ack <= take;
			if (take && wb_req.we) begin
				case (wb_req.adr)
					roi_pkg::ADR_CTRL:   start     <= wb_req.dat[0];
					roi_pkg::ADR_THRESH: threshold <= wb_req.dat[$bits(roi_pkg::pix_t)-1:0];
					default: ;  // Result and unmapped addresses are read only
				endcase
			end
		end
	end

	// Read data captured with the request, valid in the ack cycle
	always_ff @(posedge CCD_PIXCLK) begin
		if (take)
			rd_dat <= rd_mux;
	end

	assign wb_rsp.ack = ack;
	assign wb_rsp.dat = rd_dat;

endmodule

//--- tb/roi_camera_props.sv
`timescale 1ns/1ps

module roi_camera_props (
	input logic             CCD_PIXCLK,
	input logic             DLY_RST_1,
	input roi_pkg::wb_req_t wb_req,
	input roi_pkg::wb_rsp_t wb_rsp,
	input logic             pix_word_valid
);

	int prop_errors;  // Failures seen so far

	initial prop_errors = 0;

	// Ack only inside an active classic cycle
	ack_in_cycle: assert property (@(posedge CCD_PIXCLK) disable iff (!DLY_RST_1)
		wb_rsp.ack |-> (wb_req.cyc && wb_req.stb)) else begin
		$error("Wishbone ack outside an active cycle");
		prop_errors++;
	end

	ack_single: assert property (@(posedge CCD_PIXCLK) disable iff (!DLY_RST_1)
		wb_rsp.ack |=> !wb_rsp.ack) else begin
		$error("Wishbone ack on two cycles in a row");
		prop_errors++;
	end

	// Outputs quiet while in reset, sampled mid cycle
	quiet_in_reset: assert property (@(negedge CCD_PIXCLK)
		!DLY_RST_1 |-> (!wb_rsp.ack && !pix_word_valid)) else begin
		$error("Ack or word strobe high during reset");
		prop_errors++;
	end

endmodule

bind roi_camera_top roi_camera_props u_props (
	.CCD_PIXCLK    (CCD_PIXCLK),
	.DLY_RST_1     (DLY_RST_1),
	.wb_req        (wb_req),
	.wb_rsp        (wb_rsp),
	.pix_word_valid(pix_word_valid)
);

//--- tb/roi_testdata.hex
// Header: threshold, expected roi top, left, right, bottom
// Then 32 frame rows, 48 pixel samples per line, column 0 first
8 a 11 25 15
0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7
7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0
0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7
1 2 3 7 0 8 9 a b c d e f 8 9 a b c d e f 8 9 a b c d e f 8 9 a b c d e f c c 8 f 7 3 2 1 0 6 5
0 7 2 5 3 f e d c b a 9 8 f e d c b a 9 8 f e d c b a 9 8 f e d c b a 9 8 a 8 c e 2 6 0 7 4 1 3
1 2 3 7 0 8 9 a b c d e f 8 9 a b c d e f 8 9 a b c d e f 8 9 a b c d e f c c 8 f 7 3 2 1 0 6 5
0 7 2 5 3 f e d c b a 9 8 f e d c b a 9 8 f e d c b a 9 8 f e d c b a 9 8 a 8 c e 2 6 0 7 4 1 3
1 2 3 7 0 8 9 a b c d e f 8 9 a b c d e f 8 9 a b c d e f 8 9 a b c d e f c c 8 f 7 3 2 1 0 6 5
0 7 2 5 3 f e d c b a 9 8 f e d c b a 9 8 f e d c b a 9 8 f e d c b a 9 8 a 8 c e 2 6 0 7 4 1 3
1 2 3 7 0 8 9 a b c d e f 8 9 a b c d e f 8 9 a b c d e f 8 9 a b c d e f c c 8 f 7 3 2 1 0 6 5
1 2 3 7 0 8 9 a b c d e f 8 c 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 f e d c b a 9 8 c a 7 3 2 1 0 6 5
0 7 2 5 3 c 8 f a 9 e b d 8 c 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 8 9 a b c d e f 8 8 2 6 0 7 4 1 3
1 2 3 7 0 8 9 a b c d e f 8 c 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 f e d c b a 9 8 c a 7 3 2 1 0 6 5
0 7 2 5 3 c 8 f a 9 e b d 8 c 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 8 9 a b c d e f 8 8 2 6 0 7 4 1 3
1 2 3 7 0 8 9 a b c d e f 8 c 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 f e d c b a 9 8 c a 7 3 2 1 0 6 5
0 7 2 5 3 c 8 f a 9 e b d 8 c 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 8 9 a b c d e f 8 8 2 6 0 7 4 1 3
1 2 3 7 0 8 9 a b c d e f 8 c 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 f e d c b a 9 8 c a 7 3 2 1 0 6 5
0 7 2 5 3 c 8 f a 9 e b d 8 c 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 8 9 a b c d e f 8 8 2 6 0 7 4 1 3
1 2 3 7 0 8 9 a b c d e f 8 c 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 f e d c b a 9 8 c a 7 3 2 1 0 6 5
0 7 2 5 3 c 8 f a 9 e b d 8 c 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 8 9 a b c d e f 8 8 2 6 0 7 4 1 3
1 2 3 7 0 8 9 a b c d e f 8 c 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 f e d c b a 9 8 c a 7 3 2 1 0 6 5
0 7 2 5 3 f e d c b a 9 8 f e d c b a 9 8 f e d c b a 9 8 f e d c b a 9 8 a 8 c e 2 6 0 7 4 1 3
1 2 3 7 0 8 9 a b c d e f 8 9 a b c d e f 8 9 a b c d e f 8 9 a b c d e f c c 8 f 7 3 2 1 0 6 5
0 7 2 5 3 f e d c b a 9 8 f e d c b a 9 8 f e d c b a 9 8 f e d c b a 9 8 a 8 c e 2 6 0 7 4 1 3
1 2 3 7 0 8 9 a b c d e f 8 9 a b c d e f 8 9 a b c d e f 8 9 a b c d e f c c 8 f 7 3 2 1 0 6 5
0 7 2 5 3 f e d c b a 9 8 f e d c b a 9 8 f e d c b a 9 8 f e d c b a 9 8 a 8 c e 2 6 0 7 4 1 3
1 2 3 7 0 8 9 a b c d e f 8 9 a b c d e f 8 9 a b c d e f 8 9 a b c d e f c c 8 f 7 3 2 1 0 6 5
0 7 2 5 3 f e d c b a 9 8 f e d c b a 9 8 f e d c b a 9 8 f e d c b a 9 8 a 8 c e 2 6 0 7 4 1 3
7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0
0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7
7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0 7 6 5 4 3 2 1 0
0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7 0 1 2 3 4 5 6 7

//--- tb/tb_roi_camera.sv
`timescale 1ns/1ps

module tb_roi_camera;

	// ========================================================================
	// Geometry and run length
	// ========================================================================
	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DLY  = 10;   // Input skew after rising edge
	localparam int IMG_WIDTH  = 48;
	localparam int IMG_HEIGHT = 32;
	localparam int N_PIX      = IMG_WIDTH * IMG_HEIGHT;
	localparam int N_WORDS    = N_PIX / roi_pkg::PACK_WIDTH;  // Words per frame
	localparam int HDR_LEN    = 5;    // Threshold and four coordinates
	localparam int N_FRAMES   = 5;
	localparam int MAX_BLANK  = 9;    // Longest line blanking
	localparam int FRAME_CYC  = (IMG_WIDTH + MAX_BLANK) * IMG_HEIGHT + 16;
	localparam int RUN_CYC    = N_FRAMES * FRAME_CYC + 400;  // Reset and bus traffic on top

	// Done value of the control register, state code in bits 4:2, done and start set
	localparam roi_pkg::word_t CTRL_DONE = (16'(roi_pkg::ROI_DONE) << 2) | 16'h0003;

	logic             CCD_PIXCLK;
	logic             DLY_RST_1;
	roi_pkg::pix_t    ccd_data;
	logic             ccd_fval;
	logic             ccd_lval;
	roi_pkg::wb_req_t wb_req;
	roi_pkg::wb_rsp_t wb_rsp;
	roi_pkg::word_t   pix_word;
	logic             pix_word_valid;

	logic [15:0]      tdata [0:HDR_LEN+N_PIX-1];  // Header, then row-major pixels
	roi_pkg::word_t   words [$];                  // Packed words seen on the output
	logic [31:0]      lfsr;
	int               errors;
	int               test_base;                  // Error count when a test began

	roi_camera_top #(
		.IMG_WIDTH (IMG_WIDTH),
		.IMG_HEIGHT(IMG_HEIGHT),
		.IMG_LEFT  (4),
		.IMG_RIGHT (43),
		.IMG_TOP   (2),
		.IMG_BOTTOM(29),
		.RUN_LEN   (8),
		.PROJ_GAP  (4),
		.ROW_GAP   (2)
	) dut (
		.CCD_PIXCLK    (CCD_PIXCLK),
		.DLY_RST_1     (DLY_RST_1),
		.ccd_data      (ccd_data),
		.ccd_fval      (ccd_fval),
		.ccd_lval      (ccd_lval),
		.wb_req        (wb_req),
		.wb_rsp        (wb_rsp),
		.pix_word      (pix_word),
		.pix_word_valid(pix_word_valid)
	);

	initial CCD_PIXCLK = 1'b0;
	always #(CLK_PERIOD / 2) CCD_PIXCLK = ~CCD_PIXCLK;

	// Collect words mid cycle
	always @(negedge CCD_PIXCLK) begin
		if (DLY_RST_1 && pix_word_valid)
			words.push_back(pix_word);
	end

	// ========================================================================
	// Helpers
	// ========================================================================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic int rand_bits(input int n);
		int val;
		val = 0;
		for (int i = 0; i < n; i++) begin
			val  = (val << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
		return val;
	endfunction

	task automatic check_val(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp) else begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic next_beat();
		@(posedge CCD_PIXCLK);
		#DRIVE_DLY;
	endtask

	// Classic single access, waits for ack
	task automatic wb_access(input logic we, input roi_pkg::reg_addr_t adr,
		input roi_pkg::word_t wdat, output roi_pkg::word_t rdat);
		int wait_cyc;
		wait_cyc = 0;
		next_beat();
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		@(negedge CCD_PIXCLK);
		while (!wb_rsp.ack && wait_cyc < 8) begin
			@(negedge CCD_PIXCLK);
			wait_cyc++;
		end
		assert (wb_rsp.ack) else begin
			$display("No Wishbone ack for address %0d", adr);
			errors++;
		end
		rdat = wb_rsp.dat;  // Valid in the ack cycle
		next_beat();
		wb_req = '0;
	endtask

	task automatic wb_write(input roi_pkg::reg_addr_t adr, input roi_pkg::word_t wdat);
		roi_pkg::word_t unused;
		wb_access(1'b1, adr, wdat, unused);
	endtask

	task automatic read_check(input string name, input roi_pkg::reg_addr_t adr,
		input roi_pkg::word_t exp);
		roi_pkg::word_t rd;
		wb_access(1'b0, adr, 16'h0000, rd);
		check_val(name, rd, exp);
	endtask

	task automatic read_roi(input logic [15:0] top, input logic [15:0] left,
		input logic [15:0] right, input logic [15:0] bottom);
		read_check("roi_top", roi_pkg::ADR_TOP, top);
		read_check("roi_left", roi_pkg::ADR_LEFT, left);
		read_check("roi_right", roi_pkg::ADR_RIGHT, right);
		read_check("roi_bottom", roi_pkg::ADR_BOTTOM, bottom);
	endtask

	// Full frame with random blanking
	task automatic send_frame();
		int blank;
		next_beat();
		ccd_fval = 1'b1;
		blank = 3 + rand_bits(2);
		repeat (blank) next_beat();
		for (int y = 0; y < IMG_HEIGHT; y++) begin
			for (int x = 0; x < IMG_WIDTH; x++) begin
				ccd_lval = 1'b1;
				ccd_data = tdata[HDR_LEN + y * IMG_WIDTH + x][11:0];
				next_beat();
			end
			ccd_lval = 1'b0;
			ccd_data = '0;
			blank = 2 + rand_bits(3);  // Always at least two before fval drops
			repeat (blank) next_beat();
		end
		ccd_fval = 1'b0;
		repeat (4) next_beat();  // Pipeline drains
	endtask

	// Expected words from the pixels, first pixel in bit 0
	task automatic check_words(input int frames, input roi_pkg::pix_t th);
		roi_pkg::word_t exp;
		int             idx;
		check_val("word count", 16'(words.size()), 16'(frames * N_WORDS));
		for (int f = 0; f < frames; f++) begin
			for (int w = 0; w < N_WORDS; w++) begin
				exp = '0;
				for (int b = 0; b < roi_pkg::PACK_WIDTH; b++)
					exp[b] = (tdata[HDR_LEN + w * roi_pkg::PACK_WIDTH + b][11:0] >= th);
				idx = f * N_WORDS + w;
				if (idx < words.size())
					check_val($sformatf("pix_word %0d", idx), words[idx], exp);
			end
		end
	endtask

	task automatic end_test(input int num, input string what);
		$display("check %0d %s: %0d errors", num, what, errors - test_base);
		test_base = errors;
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================
	initial begin
		roi_pkg::pix_t th;
		DLY_RST_1 = 1'b0;
		ccd_data  = '0;
		ccd_fval  = 1'b0;
		ccd_lval  = 1'b0;
		wb_req    = '0;
		errors    = 0;
		test_base = 0;
		lfsr      = 32'h85ea_9333;
		$readmemh("tb/roi_testdata.hex", tdata);
		th = tdata[0][11:0];
		repeat (10) @(posedge CCD_PIXCLK);
		#DRIVE_DLY;
		DLY_RST_1 = 1'b1;

		// Reset values, frame ignored while start is clear
		read_check("ctrl", roi_pkg::ADR_CTRL, 16'h0000);
		read_check("threshold", roi_pkg::ADR_THRESH, 16'h0800);  // Half scale
		read_roi(16'h0000, 16'h0000, 16'h0000, 16'h0000);
		words.delete();
		send_frame();
		check_val("word count", 16'(words.size()), 16'h0000);
		end_test(1, "reset and idle");

		wb_write(roi_pkg::ADR_THRESH, 16'(th));
		read_check("threshold", roi_pkg::ADR_THRESH, 16'(th));
		read_check("unmapped 6", 3'd6, 16'h0000);
		wb_write(3'd7, 16'hffff);
		read_check("unmapped 7", 3'd7, 16'h0000);
		read_check("threshold", roi_pkg::ADR_THRESH, 16'(th));  // Unmapped write ignored
		end_test(2, "threshold and unmapped");

		wb_write(roi_pkg::ADR_CTRL, 16'h0001);
		words.delete();
		send_frame();
		send_frame();
		read_check("ctrl", roi_pkg::ADR_CTRL, CTRL_DONE);
		read_roi(tdata[1], tdata[2], tdata[3], tdata[4]);
		end_test(3, "roi search");

		check_words(2, th);
		end_test(4, "packed words");

		// Nothing reaches the threshold, search cannot finish
		wb_write(roi_pkg::ADR_THRESH, 16'h0fff);
		words.delete();
		send_frame();
		check_words(1, 12'hfff);
		read_roi(tdata[1], tdata[2], tdata[3], tdata[4]);
		end_test(5, "black frame");

		wb_write(roi_pkg::ADR_CTRL, 16'h0000);
		words.delete();
		send_frame();
		check_val("word count", 16'(words.size()), 16'h0000);
		end_test(6, "capture stopped");

		assert (dut.u_props.prop_errors == 0) else begin
			$display("Bound assertions failed %0d times", dut.u_props.prop_errors);
			errors++;
		end
		$display("checks 6, errors %0d", errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// Watchdog
	initial begin
		#(RUN_CYC * CLK_PERIOD);
		$display("Watchdog expired, run did not end within %0d cycles", RUN_CYC);
		$display("test failed");
		$finish;
	end

endmodule

//--- vlog.f
common/roi_pkg.sv
capture/ccd_capture.sv
roi/roi_finder.sv
roi/roi_regs.sv
hdl/pixel_packer.sv
hdl/roi_camera_top.sv
tb/roi_camera_props.sv
tb/tb_roi_camera.sv
